// File: all.f
verilog/core_trace_pkg.sv
verilog/rvfi_pkg.sv
verilog/rvfi_decode_capture.sv
verilog/rvfi_exmem_track.sv
verilog/rvfi_retire.sv
verilog/rvfi_trace.sv
dv/rvfi_trace_checker.sv
dv/rvfi_trace_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the rvfi_trace testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f all.f --top-module rvfi_trace_tb -Mdir obj_dir \
    && { ./obj_dir/Vrvfi_trace_tb > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log; } \
    || { echo "verilator build failed"; exit 1; }

cat sim.log
grep -q "TEST FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
exit 0

// File: dv/rvfi_trace_tb.sv
/*
 * rvfi_trace testbench
 * directed instruction table with random data, expected records
 * built from the trace rules and checked as each one retires
 */
`timescale 1ns/1ns

module rvfi_trace_tb import core_trace_pkg::*, rvfi_pkg::*; ();

    localparam int NROWS  = 15;
    // three trailing bubbles push the last row out
    localparam int NPAD   = NROWS + 3;
    // cycles of the stall sequence after the table
    localparam int NSTALL = 6;
    localparam int LIMIT  = 16 + NROWS + 3 + NSTALL + 20;

    logic        clk_i;
    logic        rst_n_i;
    id_info_t    id_i;
    logic        stall_ex_i;
    logic        flush_ex_i;
    ex_info_t    ex_i;
    logic        stall_mem_i;
    logic        flush_mem_i;
    mem_info_t   mem_i;
    logic        flush_wb_i;
    wb_info_t    wb_i;
    rvfi_rec_t   rvfi_o;
    logic [63:0] rvfi_order_o;

    id_info_t    id_tab   [NPAD];
    ex_info_t    ex_tab   [NPAD];
    mem_info_t   mem_tab  [NPAD];
    wb_info_t    wb_tab   [NPAD];
    // flush_ex, flush_mem, flush_wb
    logic [2:0]  fl_tab   [NPAD];
    string       name_tab [NROWS];
    rvfi_rec_t   exp_tab  [NROWS];
    logic [63:0] ord_tab  [NROWS];

    int   cycles;
    int   passed;
    int   failed;
    logic row_bad;

    rvfi_trace UUT (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .id_i         (id_i),
        .stall_ex_i   (stall_ex_i),
        .flush_ex_i   (flush_ex_i),
        .ex_i         (ex_i),
        .stall_mem_i  (stall_mem_i),
        .flush_mem_i  (flush_mem_i),
        .mem_i        (mem_i),
        .flush_wb_i   (flush_wb_i),
        .wb_i         (wb_i),
        .rvfi_o       (rvfi_o),
        .rvfi_order_o (rvfi_order_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // watchdog sized from reset, table and drain
    initial begin
        cycles = 0;
        while (cycles < LIMIT) begin
            @(posedge clk_i);
            cycles = cycles + 1;
        end
        $display("timeout: run did not finish within %0d cycles", LIMIT);
        $display("TEST FAILED");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // table construction
    //////////////////////////////////////////////////////////////////////

    // f: cmp wen idt ext _ bt mv rq we _ rw fex fmem fwb
    task automatic set_row(input int k, input string nm, input alu_src1_t s1,
                           input alu_src2_t s2, input pc_source_t ps, input logic [11:0] f);
        id_tab[k].trap           = f[9];
        id_tab[k].instr          = $urandom();
        // low bits 01 mark a compressed word
        id_tab[k].instr[1:0]     = f[11] ? 2'b01 : 2'b11;
        id_tab[k].pc             = $urandom();
        id_tab[k].pc_seq         = id_tab[k].pc + 32'd4;
        id_tab[k].jump_target    = $urandom();
        id_tab[k].rs1_addr       = 5'($urandom());
        id_tab[k].rs2_addr       = 5'($urandom());
        id_tab[k].rs1_data       = $urandom();
        id_tab[k].rs2_data       = $urandom();
        id_tab[k].alu_src1       = s1;
        id_tab[k].alu_src2       = s2;
        id_tab[k].pc_source      = ps;
        id_tab[k].mem_wen        = f[10];
        ex_tab[k].trap           = f[8];
        ex_tab[k].branch_taken   = f[7];
        ex_tab[k].branch_target  = $urandom();
        mem_tab[k].valid         = f[6];
        mem_tab[k].req           = f[5];
        mem_tab[k].we            = f[4];
        mem_tab[k].be            = 4'($urandom()) | 4'b0001;
        mem_tab[k].addr          = $urandom();
        mem_tab[k].wdata         = $urandom();
        wb_tab[k].reg_wen        = f[3];
        wb_tab[k].rd_addr        = 5'($urandom()) | 5'd1;
        wb_tab[k].reg_wdata      = $urandom();
        wb_tab[k].mem_rdata      = $urandom();
        fl_tab[k]                = f[2:0];
        name_tab[k]              = nm;
    endtask

    // record the row should retire with, prev_bt is the older branch in execute
    task automatic build_expected(input int k, input logic prev_bt);
        rvfi_rec_t e;
        id_info_t  d;
        logic      keep1;
        logic      keep2;
        logic      jump;
        d     = id_tab[k];
        keep1 = (d.alu_src1 == ALU_SRC1_RS1) || (d.pc_source == PC_JALR);
        keep2 = (d.alu_src2 == ALU_SRC2_RS2) || d.mem_wen;
        jump  = (d.pc_source == PC_JAL) || (d.pc_source == PC_JALR);
        e          = '0;
        e.insn     = (d.instr[1:0] == 2'b11) ? d.instr : {16'h0, d.instr[15:0]};
        e.mode     = RVFI_MODE_M;
        e.ixl      = RVFI_IXL_32;
        e.pc_rdata = d.pc;
        if (keep1) begin
            e.rs1_addr  = d.rs1_addr;
            e.rs1_rdata = d.rs1_data;
        end
        if (keep2) begin
            e.rs2_addr  = d.rs2_addr;
            e.rs2_rdata = d.rs2_data;
        end
        e.trap = ((d.trap && !prev_bt) || ex_tab[k].trap) && !fl_tab[k][1];
        // next pc through the three flush points
        e.pc_wdata = fl_tab[k][2] ? 32'd0 : (jump ? d.jump_target : d.pc_seq);
        if (ex_tab[k].branch_taken) begin
            e.pc_wdata = ex_tab[k].branch_target;
        end
        if (fl_tab[k][1] || fl_tab[k][0]) begin
            e.pc_wdata = 32'd0;
        end
        if (!fl_tab[k][0]) begin
            e.valid     = mem_tab[k].valid;
            e.mem_addr  = mem_tab[k].addr;
            e.mem_wdata = mem_tab[k].wdata;
            e.mem_rmask = (mem_tab[k].req && !mem_tab[k].we) ? mem_tab[k].be : 4'd0;
            e.mem_wmask = (mem_tab[k].req && mem_tab[k].we) ? mem_tab[k].be : 4'd0;
        end
        e.valid     = e.valid || e.trap;
        e.mem_rdata = wb_tab[k].mem_rdata;
        if (wb_tab[k].reg_wen && (wb_tab[k].rd_addr != 5'd0)) begin
            e.rd_addr  = wb_tab[k].rd_addr;
            e.rd_wdata = wb_tab[k].reg_wdata;
        end
        exp_tab[k] = e;
    endtask

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    task automatic check_val(input string tn, input string fld, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
        if (exp_v !== act_v) begin
            $display("[FAIL] %s %s: expected %h, actual %h", tn, fld, exp_v, act_v);
            row_bad = 1'b1;
        end
    endtask

    task automatic close_test(input string tn);
        if (row_bad) begin
            failed = failed + 1;
            $display("test %-18s failed", tn);
        end else begin
            passed = passed + 1;
            $display("test %-18s passed", tn);
        end
        row_bad = 1'b0;
    endtask

    task automatic check_row(input int r, input string tn, input logic [63:0] exp_ord);
        rvfi_rec_t e;
        e = exp_tab[r];
        check_val(tn, "valid", 64'(e.valid), 64'(rvfi_o.valid));
        check_val(tn, "insn", 64'(e.insn), 64'(rvfi_o.insn));
        check_val(tn, "trap", 64'(e.trap), 64'(rvfi_o.trap));
        check_val(tn, "mode/ixl", 64'({e.mode, e.ixl}), 64'({rvfi_o.mode, rvfi_o.ixl}));
        check_val(tn, "rs1", 64'({e.rs1_addr, e.rs1_rdata}),
                  64'({rvfi_o.rs1_addr, rvfi_o.rs1_rdata}));
        check_val(tn, "rs2", 64'({e.rs2_addr, e.rs2_rdata}),
                  64'({rvfi_o.rs2_addr, rvfi_o.rs2_rdata}));
        check_val(tn, "rd", 64'({e.rd_addr, e.rd_wdata}), 64'({rvfi_o.rd_addr, rvfi_o.rd_wdata}));
        check_val(tn, "pc_rdata", 64'(e.pc_rdata), 64'(rvfi_o.pc_rdata));
        check_val(tn, "pc_wdata", 64'(e.pc_wdata), 64'(rvfi_o.pc_wdata));
        check_val(tn, "mem_addr", 64'(e.mem_addr), 64'(rvfi_o.mem_addr));
        check_val(tn, "masks", 64'({e.mem_rmask, e.mem_wmask}),
                  64'({rvfi_o.mem_rmask, rvfi_o.mem_wmask}));
        check_val(tn, "mem_rdata", 64'(e.mem_rdata), 64'(rvfi_o.mem_rdata));
        check_val(tn, "mem_wdata", 64'(e.mem_wdata), 64'(rvfi_o.mem_wdata));
        check_val(tn, "order", exp_ord, rvfi_order_o);
    endtask

    // row 1 held in execute and row 0 held in memory for one cycle
    task automatic run_stall_test(input logic [63:0] ord0);
        @(posedge clk_i);
        #2;
        id_i        = id_tab[0];
        ex_i        = '0;
        mem_i       = '0;
        wb_i        = '0;
        flush_ex_i  = 1'b0;
        flush_mem_i = 1'b0;
        flush_wb_i  = 1'b0;
        @(posedge clk_i);
        #2;
        id_i = id_tab[1];
        ex_i = ex_tab[0];
        @(posedge clk_i);
        #2;
        id_i        = '0;
        ex_i        = ex_tab[1];
        stall_ex_i  = 1'b1;
        stall_mem_i = 1'b1;
        @(posedge clk_i);
        #2;
        stall_ex_i  = 1'b0;
        stall_mem_i = 1'b0;
        mem_i       = mem_tab[0];
        #8;
        // memory slot stayed empty while both registers held
        check_val("stall_hold", "bubble valid", 64'd0, 64'(rvfi_o.valid));
        check_val("stall_hold", "bubble order", ord0, rvfi_order_o);
        @(posedge clk_i);
        #2;
        ex_i  = '0;
        mem_i = mem_tab[1];
        wb_i  = wb_tab[0];
        #8;
        check_row(0, "stall_hold", ord0);
        @(posedge clk_i);
        #2;
        mem_i = '0;
        wb_i  = wb_tab[1];
        #8;
        check_row(1, "stall_hold", ord0 + 64'd1);
        close_test("stall_hold");
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [63:0] ord;
        void'($urandom(32'd95584));
        rst_n_i     = 1'b0;
        id_i        = '0;
        ex_i        = '0;
        mem_i       = '0;
        wb_i        = '0;
        stall_ex_i  = 1'b0;
        stall_mem_i = 1'b0;
        flush_ex_i  = 1'b0;
        flush_mem_i = 1'b0;
        flush_wb_i  = 1'b0;
        passed      = 0;
        failed      = 0;
        row_bad     = 1'b0;
        // padding rows stay all zero
        for (int k = 0; k < NPAD; k++) begin
            id_tab[k]  = '0;
            ex_tab[k]  = '0;
            mem_tab[k] = '0;
            wb_tab[k]  = '0;
            fl_tab[k]  = '0;
        end
        set_row(0,  "alu_rr",        ALU_SRC1_RS1,  ALU_SRC2_RS2,  PC_SEQ,    12'b0000_0100_1000);
        set_row(1,  "alu_imm",       ALU_SRC1_RS1,  ALU_SRC2_IMM,  PC_SEQ,    12'b0000_0100_1000);
        set_row(2,  "lui",           ALU_SRC1_ZERO, ALU_SRC2_IMM,  PC_SEQ,    12'b0000_0100_1000);
        set_row(3,  "compressed",    ALU_SRC1_RS1,  ALU_SRC2_RS2,  PC_SEQ,    12'b1000_0100_1000);
        set_row(4,  "jal",           ALU_SRC1_PC,   ALU_SRC2_FOUR, PC_JAL,    12'b0000_0100_1000);
        set_row(5,  "jalr",          ALU_SRC1_PC,   ALU_SRC2_FOUR, PC_JALR,   12'b0000_0100_1000);
        set_row(6,  "branch_nt",     ALU_SRC1_RS1,  ALU_SRC2_RS2,  PC_BRANCH, 12'b0000_0100_0000);
        set_row(7,  "branch_taken",  ALU_SRC1_RS1,  ALU_SRC2_RS2,  PC_BRANCH, 12'b0000_1100_0000);
        set_row(8,  "flush_ex",      ALU_SRC1_RS1,  ALU_SRC2_IMM,  PC_SEQ,    12'b0010_0100_1100);
        set_row(9,  "id_trap",       ALU_SRC1_RS1,  ALU_SRC2_IMM,  PC_SEQ,    12'b0010_0000_0000);
        set_row(10, "ex_trap_store", ALU_SRC1_RS1,  ALU_SRC2_IMM,  PC_SEQ,    12'b0101_0011_0000);
        set_row(11, "flush_mem",     ALU_SRC1_RS1,  ALU_SRC2_IMM,  PC_SEQ,    12'b0010_0110_1010);
        set_row(12, "load",          ALU_SRC1_RS1,  ALU_SRC2_IMM,  PC_SEQ,    12'b0000_0110_1000);
        set_row(13, "flush_wb",      ALU_SRC1_RS1,  ALU_SRC2_IMM,  PC_SEQ,    12'b0000_0110_0001);
        set_row(14, "rd_x0",         ALU_SRC1_RS1,  ALU_SRC2_RS2,  PC_SEQ,    12'b0000_0100_1000);
        wb_tab[14].rd_addr = 5'd0;
        ord = 64'd0;
        for (int k = 0; k < NROWS; k++) begin
            build_expected(k, (k > 0) ? ex_tab[k-1].branch_taken : 1'b0);
            ord_tab[k] = ord;
            if (exp_tab[k].valid) begin
                ord = ord + 64'd1;
            end
        end

        repeat (16) @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;
        check_val("reset", "valid", 64'd0, 64'(rvfi_o.valid));
        check_val("reset", "masks", 64'd0, 64'({rvfi_o.mem_rmask, rvfi_o.mem_wmask}));
        check_val("reset", "order", 64'd0, rvfi_order_o);
        close_test("reset");

        // row k in decode, k-1 execute, k-2 memory, k-3 writeback
        for (int k = 0; k < NPAD; k++) begin
            @(posedge clk_i);
            #2;
            id_i       = id_tab[k];
            flush_ex_i = fl_tab[k][2];
            if (k >= 1) begin
                ex_i        = ex_tab[k-1];
                flush_mem_i = fl_tab[k-1][1];
            end
            if (k >= 2) begin
                mem_i      = mem_tab[k-2];
                flush_wb_i = fl_tab[k-2][0];
            end
            if (k >= 3) begin
                wb_i = wb_tab[k-3];
            end
            #8;
            if (k >= 3) begin
                check_row(k - 3, name_tab[k-3], ord_tab[k-3]);
                close_test(name_tab[k-3]);
            end
        end

        run_stall_test(ord);

        $display("summary: %0d tests, %0d passed, %0d failed", passed + failed, passed, failed);
        if (failed == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: dv/rvfi_trace_checker.sv
/*
 * rvfi_trace checker
 * concurrent assertions on the retirement record and order count
 */
`timescale 1ns/1ns

module rvfi_trace_checker import rvfi_pkg::*; (
    input logic        clk_i,
    input logic        rst_n_i,
    input rvfi_rec_t   rec_i,
    input logic [63:0] order_i
);

    // no destination, no destination data
    rd_x0_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (rec_i.rd_addr == 5'd0) |-> (rec_i.rd_wdata == 32'd0))
        else $error("rd_wdata nonzero while rd_addr is zero");

    // one access is a read or a write, never both
    mask_dir: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !((|rec_i.mem_rmask) && (|rec_i.mem_wmask)))
        else $error("read and write masks both set");

    // order steps once per retirement
    order_step: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rec_i.valid |=> (order_i == $past(order_i) + 64'd1))
        else $error("order did not advance after a valid record");

endmodule

bind rvfi_trace rvfi_trace_checker u_checker (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .rec_i   (rvfi_o),
    .order_i (rvfi_order_o)
);

// File: verilog/rvfi_trace.sv
/*
 * retirement trace monitor
 * follows each instruction from decode to writeback and
 * reports one formal-interface record per retirement
 */
`timescale 1ns/1ns

module rvfi_trace import core_trace_pkg::*, rvfi_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    // decode
    input  id_info_t    id_i,
    input  logic        stall_ex_i,
    input  logic        flush_ex_i,
    // execute
    input  ex_info_t    ex_i,
    input  logic        stall_mem_i,
    input  logic        flush_mem_i,
    // memory
    input  mem_info_t   mem_i,
    // writeback
    input  logic        flush_wb_i,
    input  wb_info_t    wb_i,
    // record out
    output rvfi_rec_t   rvfi_o,
    output logic [63:0] rvfi_order_o
);

    stage_regs_t ex_regs;
    stage_regs_t mem_regs;
    logic        id_trap;

    // decode side
    rvfi_decode_capture u_decode_capture (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .id_i           (id_i),
        .branch_taken_i (ex_i.branch_taken),
        .stall_ex_i     (stall_ex_i),
        .flush_ex_i     (flush_ex_i),
        .regs_o         (ex_regs),
        .id_trap_o      (id_trap)
    );

    // execute and memory
    rvfi_exmem_track u_exmem_track (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .regs_i      (ex_regs),
        .id_trap_i   (id_trap),
        .ex_i        (ex_i),
        .stall_mem_i (stall_mem_i),
        .flush_mem_i (flush_mem_i),
        .regs_o      (mem_regs)
    );

    // writeback, 64-bit order count
    rvfi_retire #(
        .ORDER_W (64)
    ) u_retire (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .regs_i       (mem_regs),
        .mem_i        (mem_i),
        .flush_wb_i   (flush_wb_i),
        .wb_i         (wb_i),
        .rvfi_o       (rvfi_o),
        .rvfi_order_o (rvfi_order_o)
    );

endmodule

// File: verilog/rvfi_retire.sv
/*
 * retirement stage
 * memory-to-writeback register, memory masks, rd gating and
 * the retirement order counter, drives the formal record
 */
`timescale 1ns/1ns

module rvfi_retire import core_trace_pkg::*, rvfi_pkg::*; #(
    parameter int ORDER_W = 64
) (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  stage_regs_t        regs_i,
    input  mem_info_t          mem_i,
    input  logic               flush_wb_i,
    input  wb_info_t           wb_i,
    output rvfi_rec_t          rvfi_o,
    output logic [ORDER_W-1:0] rvfi_order_o
);

    stage_regs_t        regs_q;
    logic               valid_q;
    logic [31:0]        mem_addr_q;
    logic [31:0]        mem_wdata_q;
    logic [3:0]         rmask_q;
    logic [3:0]         wmask_q;
    logic [ORDER_W-1:0] order_q;
    logic               rec_valid;
    logic [4:0]         rd_addr;

    ///////////////////////////////////////////////////////////////////////
    // mem -> wb register, never stalls
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i, negedge rst_n_i) begin
        if (!rst_n_i) begin
            regs_q      <= '0;
            valid_q     <= 1'b0;
            mem_addr_q  <= '0;
            mem_wdata_q <= '0;
            rmask_q     <= '0;
            wmask_q     <= '0;
        end else begin
            regs_q <= regs_i;
            if (flush_wb_i) begin
                valid_q         <= 1'b0;
                regs_q.pc_wdata <= '0;
                mem_addr_q      <= '0;
                mem_wdata_q     <= '0;
                rmask_q         <= '0;
                wmask_q         <= '0;
            end else begin
                valid_q     <= mem_i.valid;
                mem_addr_q  <= mem_i.addr;
                mem_wdata_q <= mem_i.wdata;
                // byte enables split by direction
                rmask_q     <= (mem_i.req && !mem_i.we) ? mem_i.be : 4'b0;
                wmask_q     <= (mem_i.req &&  mem_i.we) ? mem_i.be : 4'b0;
            end
        end
    end

    // traps retire even without a valid slot
    assign rec_valid = valid_q || regs_q.trap;

    // x0 writes and disabled writes show no rd
    assign rd_addr = wb_i.reg_wen ? wb_i.rd_addr : 5'd0;

    ///////////////////////////////////////////////////////////////////////
    // retirement order
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i, negedge rst_n_i) begin
        if (!rst_n_i) begin
            order_q <= '0;
        end else if (rec_valid) begin
            order_q <= order_q + ORDER_W'(1);
        end
    end

    assign rvfi_order_o = order_q;

    ///////////////////////////////////////////////////////////////////////
    // record
    ///////////////////////////////////////////////////////////////////////

    always_comb begin
        rvfi_o.valid     = rec_valid;
        rvfi_o.insn      = regs_q.insn;
        rvfi_o.trap      = regs_q.trap;
        rvfi_o.mode      = RVFI_MODE_M;
        rvfi_o.ixl       = RVFI_IXL_32;
        rvfi_o.rs1_addr  = regs_q.rs1_addr;
        rvfi_o.rs1_rdata = regs_q.rs1_data;
        rvfi_o.rs2_addr  = regs_q.rs2_addr;
        rvfi_o.rs2_rdata = regs_q.rs2_data;
        rvfi_o.rd_addr   = rd_addr;
        // rd data only meaningful for a real rd
        rvfi_o.rd_wdata  = (rd_addr == 5'd0) ? 32'b0 : wb_i.reg_wdata;
        rvfi_o.pc_rdata  = regs_q.pc_rdata;
        rvfi_o.pc_wdata  = regs_q.pc_wdata;
        rvfi_o.mem_addr  = mem_addr_q;
        rvfi_o.mem_rmask = rmask_q;
        rvfi_o.mem_wmask = wmask_q;
        // load data arrives in writeback
        rvfi_o.mem_rdata = wb_i.mem_rdata;
        rvfi_o.mem_wdata = mem_wdata_q;
    end

endmodule

// File: verilog/rvfi_exmem_track.sv
/*
 * execute/memory tracker
 * execute-to-memory trace register, applies taken branches
 * to the next pc and merges decode and execute traps
 */
`timescale 1ns/1ns

module rvfi_exmem_track import core_trace_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  stage_regs_t regs_i,
    input  logic        id_trap_i,
    input  ex_info_t    ex_i,
    input  logic        stall_mem_i,
    input  logic        flush_mem_i,
    output stage_regs_t regs_o
);

    logic [31:0] pc_next;
    logic        trap_any;
    stage_regs_t regs_q;

    ///////////////////////////////////////////////////////////////////////
    // execute resolution
    ///////////////////////////////////////////////////////////////////////

    // taken branch overrides sequential or jump pc
    assign pc_next  = ex_i.branch_taken ? ex_i.branch_target : regs_i.pc_wdata;

    // either stage may raise it
    assign trap_any = id_trap_i || ex_i.trap;

    ///////////////////////////////////////////////////////////////////////
    // ex -> mem register
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i, negedge rst_n_i) begin
        if (!rst_n_i) begin
            regs_q <= '0;
        end else if (!stall_mem_i) begin
            // sources, insn and pc pass through
            regs_q <= regs_i;
            if (flush_mem_i) begin
                // bubble, no trap and no next pc
                regs_q.trap     <= 1'b0;
                regs_q.pc_wdata <= '0;
            end else begin
                regs_q.trap     <= trap_any;
                regs_q.pc_wdata <= pc_next;
            end
        end
    end

    assign regs_o = regs_q;

endmodule

// File: verilog/rvfi_decode_capture.sv
/*
 * decode capture
 * decode-to-execute trace register, qualifies sources,
 * normalizes compressed words and picks the jump next pc
 */
`timescale 1ns/1ns

module rvfi_decode_capture import core_trace_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  id_info_t    id_i,
    input  logic        branch_taken_i,
    input  logic        stall_ex_i,
    input  logic        flush_ex_i,
    output stage_regs_t regs_o,
    output logic        id_trap_o
);

    logic        rs1_used;
    logic        rs2_used;
    logic        is_jump;
    logic [31:0] insn_norm;
    stage_regs_t regs_d;
    stage_regs_t regs_q;

    ///////////////////////////////////////////////////////////////////////
    // next payload
    ///////////////////////////////////////////////////////////////////////

    // compressed when low bits are not 2'b11
    assign insn_norm = (id_i.instr[1:0] == 2'b11) ? id_i.instr
                                                  : {16'b0, id_i.instr[15:0]};

    // rs1 read by alu or as jalr base
    assign rs1_used = (id_i.alu_src1 == ALU_SRC1_RS1) || (id_i.pc_source == PC_JALR);
    // rs2 read by alu or as store data
    assign rs2_used = (id_i.alu_src2 == ALU_SRC2_RS2) || id_i.mem_wen;
    assign is_jump  = (id_i.pc_source == PC_JAL) || (id_i.pc_source == PC_JALR);

    always_comb begin
        regs_d          = '0;
        regs_d.insn     = insn_norm;
        // branch resolving in execute squashes this one
        regs_d.trap     = id_i.trap && !branch_taken_i;
        regs_d.pc_rdata = id_i.pc;
        // branches are resolved one stage later
        regs_d.pc_wdata = is_jump ? id_i.jump_target : id_i.pc_seq;
        if (rs1_used) begin
            regs_d.rs1_addr = id_i.rs1_addr;
            regs_d.rs1_data = id_i.rs1_data;
        end
        if (rs2_used) begin
            regs_d.rs2_addr = id_i.rs2_addr;
            regs_d.rs2_data = id_i.rs2_data;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // id -> ex register
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i, negedge rst_n_i) begin
        if (!rst_n_i) begin
            regs_q <= '0;
        end else if (!stall_ex_i) begin
            regs_q <= regs_d;
            // bubble only loses its next pc
            if (flush_ex_i) begin
                regs_q.pc_wdata <= '0;
            end
        end
    end

    assign regs_o    = regs_q;
    // registered decode trap for the merge in memory
    assign id_trap_o = regs_q.trap;

endmodule

// File: verilog/rvfi_pkg.sv
/*
 * formal interface record
 * one retired instruction as reported at writeback
 */
package rvfi_pkg;

    // machine mode only
    localparam logic [1:0] RVFI_MODE_M = 2'd3;
    // xlen is 32
    localparam logic [1:0] RVFI_IXL_32 = 2'd1;

    typedef struct packed {
        logic        valid;
        logic [31:0] insn;
        logic        trap;
        logic [1:0]  mode;
        logic [1:0]  ixl;
        // integer sources
        logic [4:0]  rs1_addr;
        logic [31:0] rs1_rdata;
        logic [4:0]  rs2_addr;
        logic [31:0] rs2_rdata;
        // integer destination
        logic [4:0]  rd_addr;
        logic [31:0] rd_wdata;
        // program counter
        logic [31:0] pc_rdata;
        logic [31:0] pc_wdata;
        // memory access
        logic [31:0] mem_addr;
        logic [3:0]  mem_rmask;
        logic [3:0]  mem_wmask;
        logic [31:0] mem_rdata;
        logic [31:0] mem_wdata;
    } rvfi_rec_t;

endpackage

// File: verilog/core_trace_pkg.sv
/*
 * core trace types
 * select encodings and per-stage input bundles seen by the trace monitor
 */
package core_trace_pkg;

    ///////////////////////////////////////////////////////////////////////
    // select encodings
    ///////////////////////////////////////////////////////////////////////

    // next pc source picked in decode
    typedef enum logic [1:0] {
        PC_SEQ    = 2'd0,
        PC_JAL    = 2'd1,
        PC_JALR   = 2'd2,
        PC_BRANCH = 2'd3
    } pc_source_t;

    // alu operand a
    typedef enum logic [1:0] {
        ALU_SRC1_RS1  = 2'd0,
        ALU_SRC1_PC   = 2'd1,
        ALU_SRC1_ZERO = 2'd2
    } alu_src1_t;

    // alu operand b
    typedef enum logic [1:0] {
        ALU_SRC2_RS2  = 2'd0,
        ALU_SRC2_IMM  = 2'd1,
        ALU_SRC2_FOUR = 2'd2
    } alu_src2_t;

    ///////////////////////////////////////////////////////////////////////
    // per-stage inputs from the core
    ///////////////////////////////////////////////////////////////////////

    // decode stage view, 210 bits
    typedef struct packed {
        logic        trap;
        logic [31:0] instr;
        logic [31:0] pc;
        logic [31:0] pc_seq;      // fetch pc after this one
        logic [31:0] jump_target; // jal / jalr destination
        logic [4:0]  rs1_addr;
        logic [4:0]  rs2_addr;
        logic [31:0] rs1_data;    // after forwarding
        logic [31:0] rs2_data;
        alu_src1_t   alu_src1;
        alu_src2_t   alu_src2;
        pc_source_t  pc_source;
        logic        mem_wen;
    } id_info_t;

    // execute stage outcome
    typedef struct packed {
        logic        trap;
        logic        branch_taken;
        logic [31:0] branch_target;
    } ex_info_t;

    // data bus request in memory stage
    typedef struct packed {
        logic        valid;
        logic        req;
        logic        we;
        logic [3:0]  be;
        logic [31:0] addr;
        logic [31:0] wdata;
    } mem_info_t;

    // writeback stage
    typedef struct packed {
        logic        reg_wen;
        logic [4:0]  rd_addr;
        logic [31:0] reg_wdata;
        logic [31:0] mem_rdata;
    } wb_info_t;

    // trace payload handed from stage to stage
    typedef struct packed {
        logic [31:0] insn;
        logic        trap;
        logic [4:0]  rs1_addr;
        logic [4:0]  rs2_addr;
        logic [31:0] rs1_data;
        logic [31:0] rs2_data;
        logic [31:0] pc_rdata;
        logic [31:0] pc_wdata;
    } stage_regs_t;

endpackage
